// ==== src/stream_mix_params.svh ====
`ifndef STREAM_MIX_PARAMS_SVH
`define STREAM_MIX_PARAMS_SVH

`define SAMPLE_W 16 // signed sample width
`define FRAME_W 8   // frame counter, wraps

// lane slices cut both paths
`define LANE_FWD_REG 1
`define LANE_BWD_REG 1

// output slice only breaks the forward path
`define OUT_FWD_REG 1
`define OUT_BWD_REG 0

`endif

// ==== src/stream_mix_pkg.sv ====
`include "stream_mix_params.svh"

package stream_mix_pkg;

    // one beat of a sample lane
    typedef struct packed
    {
        logic signed [`SAMPLE_W-1:0] sample;
        logic                        last;   // final beat of a frame
    } lane_beat_t;

    // one mixed result beat
    typedef struct packed
    {
        logic signed [`SAMPLE_W-1:0] sum;      // saturated a + b
        logic                        sat;      // sum was clipped
        logic                        misalign; // lanes disagree on last
        logic [`FRAME_W-1:0]         frame;    // frame number of this beat
    } mix_beat_t;

endpackage

// ==== src/axis_reg_slice.sv ====
`timescale 1ns/10ps

// valid/ready register slice, built from two optional stages in series:
// a backward (skid) stage on the upstream side, then a forward stage
// driving the downstream side. with both off the slice is pure wiring
module axis_reg_slice #(
    parameter type payload_t = logic [31:0],
    parameter bit  fwd_reg   = 1'b1,
    parameter bit  bwd_reg   = 1'b1
) (
    input  logic     clk,
    input  logic     rst_n,

    input  payload_t s_payload,
    input  logic     s_valid,
    output logic     s_ready,

    output payload_t m_payload,
    output logic     m_valid,
    input  logic     m_ready
);

    // link between the backward and forward stages
    payload_t mid_payload;
    logic     mid_valid;
    logic     mid_ready;

    generate
        if (bwd_reg)
        begin : g_bwd
            payload_t skid_payload;
            logic     bwd_ready;

            assign s_ready     = bwd_ready;
            // skid holds the beat once ready has dropped
            assign mid_payload = bwd_ready ? s_payload : skid_payload;
            assign mid_valid   = ~bwd_ready | s_valid;

            always_ff @(posedge clk)
            begin
                if (bwd_ready && s_valid)
                    skid_payload <= s_payload; // beat caught as ready falls
            end

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    bwd_ready <= 1'b1;
                else if (mid_ready)
                    bwd_ready <= 1'b1;
                else if (s_valid)
                    bwd_ready <= 1'b0; // downstream stalled with a beat pending
            end
        end
        else
        begin : g_bwd_pass
            assign s_ready     = mid_ready;
            assign mid_payload = s_payload;
            assign mid_valid   = s_valid;
        end
    endgenerate

    generate
        if (fwd_reg)
        begin : g_fwd
            payload_t fwd_payload;
            logic     fwd_valid;

            // register may load when empty or being drained this cycle
            assign mid_ready = ~fwd_valid | m_ready;
            assign m_payload = fwd_payload;
            assign m_valid   = fwd_valid;

            always_ff @(posedge clk)
            begin
                if (mid_ready && mid_valid)
                    fwd_payload <= mid_payload;
            end

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    fwd_valid <= 1'b0;
                else if (mid_ready)
                    fwd_valid <= mid_valid;
            end
        end
        else
        begin : g_fwd_pass
            assign mid_ready = m_ready;
            assign m_payload = mid_payload;
            assign m_valid   = mid_valid;
        end
    endgenerate

endmodule

// ==== src/stream_join_mix.sv ====
`timescale 1ns/10ps
`include "stream_mix_params.svh"

// pairs one beat from each lane, adds them with signed saturation,
// flags frame misalignment and numbers frames. one output register
module stream_join_mix (
    input  logic                       clk,
    input  logic                       rst_n,

    input  stream_mix_pkg::lane_beat_t a_beat,
    input  logic                       a_valid,
    output logic                       a_ready,

    input  stream_mix_pkg::lane_beat_t b_beat,
    input  logic                       b_valid,
    output logic                       b_ready,

    output stream_mix_pkg::mix_beat_t  mix,
    output logic                       mix_valid,
    input  logic                       mix_ready
);

    import stream_mix_pkg::*;

    localparam int SUM_W = `SAMPLE_W + 1; // one guard bit for overflow

    logic                    out_free;
    logic                    take;
    logic signed [SUM_W-1:0] sum_wide;
    logic                    ovf;
    logic [`FRAME_W-1:0]     frame_cnt;
    mix_beat_t               mix_next;

    // output register empty or draining this cycle
    assign out_free = ~mix_valid | mix_ready;

    // both lanes move together, never one alone
    assign a_ready = out_free & b_valid;
    assign b_ready = out_free & a_valid;
    assign take    = a_valid & b_valid & out_free;

    assign sum_wide = {a_beat.sample[`SAMPLE_W-1], a_beat.sample}
                    + {b_beat.sample[`SAMPLE_W-1], b_beat.sample};

    // guard bit differs from sign bit -> result left the signed range
    assign ovf = sum_wide[SUM_W-1] ^ sum_wide[SUM_W-2];

    always_comb
    begin
        if (!ovf)
            mix_next.sum = sum_wide[`SAMPLE_W-1:0];
        else if (sum_wide[SUM_W-1])
            mix_next.sum = {1'b1, {(`SAMPLE_W-1){1'b0}}}; // clip to most negative
        else
            mix_next.sum = {1'b0, {(`SAMPLE_W-1){1'b1}}}; // clip to most positive
        mix_next.sat      = ovf;
        mix_next.misalign = a_beat.last ^ b_beat.last;
        mix_next.frame    = frame_cnt;
    end

    always_ff @(posedge clk)
    begin
        if (take)
            mix <= mix_next;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            mix_valid <= 1'b0;
        else if (out_free)
            mix_valid <= take;
    end

    // frame boundaries follow lane a only
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            frame_cnt <= '0;
        else if (take && a_beat.last)
            frame_cnt <= frame_cnt + 1'b1; // wraps
    end

endmodule

// ==== src/stream_mix_top.sv ====
`timescale 1ns/10ps
`include "stream_mix_params.svh"

// two-lane sample mixer: lane slices -> join/mix -> output slice
module stream_mix_top (
    input  logic                       clk,
    input  logic                       rst_n,

    input  stream_mix_pkg::lane_beat_t a_payload,
    input  logic                       a_valid,
    output logic                       a_ready,

    input  stream_mix_pkg::lane_beat_t b_payload,
    input  logic                       b_valid,
    output logic                       b_ready,

    output stream_mix_pkg::mix_beat_t  m_payload,
    output logic                       m_valid,
    input  logic                       m_ready
);

    import stream_mix_pkg::*;

    lane_beat_t a_beat;
    logic       a_beat_valid;
    logic       a_beat_ready;

    lane_beat_t b_beat;
    logic       b_beat_valid;
    logic       b_beat_ready;

    mix_beat_t  mix;
    logic       mix_valid;
    logic       mix_ready;

    axis_reg_slice #(
        .payload_t (lane_beat_t),
        .fwd_reg   (`LANE_FWD_REG),
        .bwd_reg   (`LANE_BWD_REG)
    ) lane_a_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_payload (a_payload),
        .s_valid   (a_valid),
        .s_ready   (a_ready),
        .m_payload (a_beat),
        .m_valid   (a_beat_valid),
        .m_ready   (a_beat_ready)
    );

    axis_reg_slice #(
        .payload_t (lane_beat_t),
        .fwd_reg   (`LANE_FWD_REG),
        .bwd_reg   (`LANE_BWD_REG)
    ) lane_b_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_payload (b_payload),
        .s_valid   (b_valid),
        .s_ready   (b_ready),
        .m_payload (b_beat),
        .m_valid   (b_beat_valid),
        .m_ready   (b_beat_ready)
    );

    stream_join_mix join_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_beat    (a_beat),
        .a_valid   (a_beat_valid),
        .a_ready   (a_beat_ready),
        .b_beat    (b_beat),
        .b_valid   (b_beat_valid),
        .b_ready   (b_beat_ready),
        .mix       (mix),
        .mix_valid (mix_valid),
        .mix_ready (mix_ready)
    );

    // forward register only, adds one cycle of latency
    axis_reg_slice #(
        .payload_t (mix_beat_t),
        .fwd_reg   (`OUT_FWD_REG),
        .bwd_reg   (`OUT_BWD_REG)
    ) out_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_payload (mix),
        .s_valid   (mix_valid),
        .s_ready   (mix_ready),
        .m_payload (m_payload),
        .m_valid   (m_valid),
        .m_ready   (m_ready)
    );

endmodule

// ==== verification/stream_mix_tb.sv ====
`timescale 1ns/10ps
`include "stream_mix_params.svh"

module stream_mix_tb;

    import stream_mix_pkg::*;

    // pattern word fields from the lsb up are frame, sum, flags, b sample, a sample
    localparam int FRAME_LSB = 0;
    localparam int SUM_LSB   = FRAME_LSB + `FRAME_W;
    localparam int FLAG_LSB  = SUM_LSB + `SAMPLE_W; // {a_last, b_last, sat, misalign}
    localparam int B_LSB     = FLAG_LSB + 4;
    localparam int A_LSB     = B_LSB + `SAMPLE_W;
    localparam int PAT_W     = A_LSB + `SAMPLE_W;

    localparam int NUM_PATS     = 273;
    localparam int READY_LIMIT  = 200; // cycles per lane handshake
    localparam int OUT_LIMIT    = 400; // cycles per output beat
    localparam int DRAIN_CYCLES = 50;

    typedef logic [PAT_W-1:0] pat_t;

    logic       clk;
    logic       rst_n;
    lane_beat_t a_payload;
    logic       a_valid;
    logic       a_ready;
    lane_beat_t b_payload;
    logic       b_valid;
    logic       b_ready;
    mix_beat_t  m_payload;
    logic       m_valid;
    logic       m_ready;

    pat_t pat_mem [0:NUM_PATS-1];
    int   errors;
    int   checks;
    int   beats_seen;

    stream_mix_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_payload (a_payload),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .b_payload (b_payload),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .m_payload (m_payload),
        .m_valid   (m_valid),
        .m_ready   (m_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    function automatic lane_beat_t lane_a_of(input pat_t pat);
        lane_beat_t beat;
        beat.sample = pat[A_LSB +: `SAMPLE_W];
        beat.last   = pat[FLAG_LSB + 3];
        return beat;
    endfunction

    function automatic lane_beat_t lane_b_of(input pat_t pat);
        lane_beat_t beat;
        beat.sample = pat[B_LSB +: `SAMPLE_W];
        beat.last   = pat[FLAG_LSB + 2];
        return beat;
    endfunction

    function automatic mix_beat_t expected_of(input pat_t pat);
        mix_beat_t want;
        want.sum      = pat[SUM_LSB +: `SAMPLE_W];
        want.sat      = pat[FLAG_LSB + 1];
        want.misalign = pat[FLAG_LSB];
        want.frame    = pat[FRAME_LSB +: `FRAME_W];
        return want;
    endfunction

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("ERROR: timed out waiting for %s at %0t", what, $time);
        finish_run();
    endtask

    task automatic check_field(input string name, input logic signed [31:0] want,
                               input logic signed [31:0] got);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("[FAIL] %s: expected %0d actual %0d", name, want, got);
        end
    endtask

    task automatic check_beat(input int idx, input mix_beat_t got);
        mix_beat_t want;
        string     name;
        want = expected_of(pat_mem[idx]);
        name = $sformatf("pair %0d", idx);
        check_field({name, " sum"}, want.sum, got.sum);
        check_field({name, " sat"}, want.sat, got.sat);
        check_field({name, " misalign"}, want.misalign, got.misalign);
        check_field({name, " frame"}, want.frame, got.frame);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // on success returns 1 ns after the edge where the beat transferred
    task automatic wait_lane_ready(input bit lane_b, output bit ok);
        int cycles;
        bit got;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < READY_LIMIT)
        begin
            @(posedge clk);
            got = lane_b ? b_ready : a_ready;
            cycles++;
        end
        ok = got;
        if (got)
            #1;
    endtask

    task automatic drive_lane(input bit lane_b);
        lane_beat_t beat;
        int         gap_max;
        bit         ok;
        gap_max = lane_b ? 1 : 3; // uneven gaps between the lanes
        ok      = 1'b1;
        for (int i = 0; i < NUM_PATS && ok; i++)
        begin
            beat = lane_b ? lane_b_of(pat_mem[i]) : lane_a_of(pat_mem[i]);
            idle_cycles($urandom_range(gap_max));
            if (lane_b)
            begin
                b_payload = beat;
                b_valid   = 1'b1;
            end
            else
            begin
                a_payload = beat;
                a_valid   = 1'b1;
            end
            wait_lane_ready(lane_b, ok);
            if (!ok)
                timeout_fail(lane_b ? "b_ready" : "a_ready");
            else if (lane_b)
                b_valid = 1'b0;
            else
                a_valid = 1'b0;
        end
    endtask

    task automatic wait_output(output mix_beat_t beat, output bit ok);
        int cycles;
        bit got;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < OUT_LIMIT)
        begin
            @(posedge clk);
            got = m_valid && m_ready;
            cycles++;
        end
        ok   = got;
        beat = m_payload; // value before the edge updates
    endtask

    task automatic score_outputs();
        mix_beat_t got;
        bit        ok;
        ok = 1'b1;
        for (int i = 0; i < NUM_PATS && ok; i++)
        begin
            wait_output(got, ok);
            if (!ok)
                timeout_fail("an output beat");
            else
            begin
                check_beat(i, got);
                beats_seen++;
            end
        end
    endtask

    task automatic toggle_m_ready();
        while (beats_seen < NUM_PATS)
        begin
            @(posedge clk);
            #1;
            m_ready = ($urandom_range(2) != 0); // stall about one cycle in three
        end
        m_ready = 1'b1;
    endtask

    task automatic check_drain();
        for (int i = 0; i < DRAIN_CYCLES; i++)
        begin
            @(posedge clk);
            checks++;
            assert (m_valid === 1'b0)
            else
            begin
                errors++;
                $display("ERROR: extra output beat after the last pattern, frame %0d",
                         m_payload.frame);
            end
        end
    endtask

    initial
    begin
        rst_n      = 1'b0;
        a_payload  = '0;
        a_valid    = 1'b0;
        b_payload  = '0;
        b_valid    = 1'b0;
        m_ready    = 1'b0;
        errors     = 0;
        checks     = 0;
        beats_seen = 0;
        void'($urandom(56));

        $readmemh("verification/mix_patterns.txt", pat_mem);
        checks++;
        assert (!$isunknown(pat_mem[NUM_PATS-1]))
        else
        begin
            errors++;
            $display("ERROR: pattern file holds fewer than %0d entries", NUM_PATS);
        end

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // nothing driven yet so the DUT sits idle
        @(posedge clk);
        check_field("reset m_valid", 1'b0, m_valid);
        check_field("reset a_ready", 1'b1, a_ready);
        check_field("reset b_ready", 1'b1, b_ready);
        #1;

        fork
            drive_lane(1'b0);
            drive_lane(1'b1);
            score_outputs();
            toggle_m_ready();
        join

        m_ready = 1'b1;
        check_drain();
        finish_run();
    end

endmodule

// ==== verification/mix_patterns.txt ====
// hex word per pair: a_sample b_sample flags exp_sum exp_frame, no spaces
// flags digit = {a_last, b_last, exp_sat, exp_misalign}; words are read in file order
001000200003000 // plain add
fff000050fff500 // negative plus positive
1234edccc000000 // cancels to zero, both end frame 0
7fff000127fff01 // positive overflow
8000ffff2800001 // negative overflow
4000400027fff01 // positive overflow from two halves
c000c0000800001 // exactly the minimum, no clip
7fff80009ffff01 // only lane a ends the frame
010002005030002 // only lane b ends, frame holds
80008000e800002 // min plus min, both end
7fff7fffb7fff03 // max plus max, only lane a ends
000000000000004 // zeros
3000500027fff04 // overflow from mixed magnitudes
ffffffff0fffe04 // minus one twice
a5a51234cb7d904 // both end frame 4
// tail: both lanes end a frame on every pair, six pairs per line, frame wraps past ff
00010002c000305 00010002c000306 00010002c000307 00010002c000308 00010002c000309 00010002c00030a
00010002c00030b 00010002c00030c 00010002c00030d 00010002c00030e 00010002c00030f 00010002c000310
00010002c000311 00010002c000312 00010002c000313 00010002c000314 00010002c000315 00010002c000316
00010002c000317 00010002c000318 00010002c000319 00010002c00031a 00010002c00031b 00010002c00031c
00010002c00031d 00010002c00031e 00010002c00031f 00010002c000320 00010002c000321 00010002c000322
00010002c000323 00010002c000324 00010002c000325 00010002c000326 00010002c000327 00010002c000328
00010002c000329 00010002c00032a 00010002c00032b 00010002c00032c 00010002c00032d 00010002c00032e
00010002c00032f 00010002c000330 00010002c000331 00010002c000332 00010002c000333 00010002c000334
00010002c000335 00010002c000336 00010002c000337 00010002c000338 00010002c000339 00010002c00033a
00010002c00033b 00010002c00033c 00010002c00033d 00010002c00033e 00010002c00033f 00010002c000340
00010002c000341 00010002c000342 00010002c000343 00010002c000344 00010002c000345 00010002c000346
00010002c000347 00010002c000348 00010002c000349 00010002c00034a 00010002c00034b 00010002c00034c
00010002c00034d 00010002c00034e 00010002c00034f 00010002c000350 00010002c000351 00010002c000352
00010002c000353 00010002c000354 00010002c000355 00010002c000356 00010002c000357 00010002c000358
00010002c000359 00010002c00035a 00010002c00035b 00010002c00035c 00010002c00035d 00010002c00035e
00010002c00035f 00010002c000360 00010002c000361 00010002c000362 00010002c000363 00010002c000364
00010002c000365 00010002c000366 00010002c000367 00010002c000368 00010002c000369 00010002c00036a
00010002c00036b 00010002c00036c 00010002c00036d 00010002c00036e 00010002c00036f 00010002c000370
00010002c000371 00010002c000372 00010002c000373 00010002c000374 00010002c000375 00010002c000376
00010002c000377 00010002c000378 00010002c000379 00010002c00037a 00010002c00037b 00010002c00037c
00010002c00037d 00010002c00037e 00010002c00037f 00010002c000380 00010002c000381 00010002c000382
00010002c000383 00010002c000384 00010002c000385 00010002c000386 00010002c000387 00010002c000388
00010002c000389 00010002c00038a 00010002c00038b 00010002c00038c 00010002c00038d 00010002c00038e
00010002c00038f 00010002c000390 00010002c000391 00010002c000392 00010002c000393 00010002c000394
00010002c000395 00010002c000396 00010002c000397 00010002c000398 00010002c000399 00010002c00039a
00010002c00039b 00010002c00039c 00010002c00039d 00010002c00039e 00010002c00039f 00010002c0003a0
00010002c0003a1 00010002c0003a2 00010002c0003a3 00010002c0003a4 00010002c0003a5 00010002c0003a6
00010002c0003a7 00010002c0003a8 00010002c0003a9 00010002c0003aa 00010002c0003ab 00010002c0003ac
00010002c0003ad 00010002c0003ae 00010002c0003af 00010002c0003b0 00010002c0003b1 00010002c0003b2
00010002c0003b3 00010002c0003b4 00010002c0003b5 00010002c0003b6 00010002c0003b7 00010002c0003b8
00010002c0003b9 00010002c0003ba 00010002c0003bb 00010002c0003bc 00010002c0003bd 00010002c0003be
00010002c0003bf 00010002c0003c0 00010002c0003c1 00010002c0003c2 00010002c0003c3 00010002c0003c4
00010002c0003c5 00010002c0003c6 00010002c0003c7 00010002c0003c8 00010002c0003c9 00010002c0003ca
00010002c0003cb 00010002c0003cc 00010002c0003cd 00010002c0003ce 00010002c0003cf 00010002c0003d0
00010002c0003d1 00010002c0003d2 00010002c0003d3 00010002c0003d4 00010002c0003d5 00010002c0003d6
00010002c0003d7 00010002c0003d8 00010002c0003d9 00010002c0003da 00010002c0003db 00010002c0003dc
00010002c0003dd 00010002c0003de 00010002c0003df 00010002c0003e0 00010002c0003e1 00010002c0003e2
00010002c0003e3 00010002c0003e4 00010002c0003e5 00010002c0003e6 00010002c0003e7 00010002c0003e8
00010002c0003e9 00010002c0003ea 00010002c0003eb 00010002c0003ec 00010002c0003ed 00010002c0003ee
00010002c0003ef 00010002c0003f0 00010002c0003f1 00010002c0003f2 00010002c0003f3 00010002c0003f4
00010002c0003f5 00010002c0003f6 00010002c0003f7 00010002c0003f8 00010002c0003f9 00010002c0003fa
00010002c0003fb 00010002c0003fc 00010002c0003fd 00010002c0003fe 00010002c0003ff 00010002c000300
00010002c000301 00010002c000302 00010002c000303 00010002c000304 00010002c000305 00010002c000306

// ==== verilog.f ====
+incdir+src
src/stream_mix_pkg.sv
src/axis_reg_slice.sv
src/stream_join_mix.sv
src/stream_mix_top.sv
verification/stream_mix_tb.sv

// ==== Bender.yml ====
package:
  name: stream_mix

sources:
  - include_dirs:
      - src
    files:
      - src/stream_mix_pkg.sv
      - src/axis_reg_slice.sv
      - src/stream_join_mix.sv
      - src/stream_mix_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/stream_mix_tb.sv
